/* filelist.f */
source/dadda_mul_pkg.sv
source/mul_control.sv
source/pp_generator.sv
source/dadda_reducer.sv
source/final_adder_stage.sv
source/dadda_mul_top.sv
verification/dadda_mul_properties.sv
verification/tb_dadda_mul.sv

/* run_sim.sh */
#!/bin/sh
# Builds the Dadda multiplier testbench with Verilator and runs it

LOG=sim.log

if ! verilator --binary --timing --assert -Wno-fatal -f filelist.f \
        --top-module tb_dadda_mul --Mdir obj_dir -o tb_dadda_mul; then
    echo "Verilator build failed"
    exit 1
fi

if ! ./obj_dir/tb_dadda_mul > "$LOG" 2>&1; then
    echo "Simulation returned an error status, see $LOG"
    exit 1
fi

if grep -qx "=== PASS ===" "$LOG"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed, see $LOG"
    exit 1
fi

/* source/dadda_mul_pkg.sv */
// Shared definitions for the 8x8 unsigned Dadda multiplier
// Widths, FSM and step codes, and the adder cells of the reduction tree

package dadda_mul_pkg;

    localparam int OP_W      = 8;
    localparam int PROD_W    = 2 * OP_W;
    localparam int PP_BITS   = OP_W * OP_W;
    localparam int RED1_ROWS = 4;          // Rows left after reduction stage 1

    localparam int STATE_W = 2;
    localparam logic [STATE_W-1:0] ST_IDLE    = 2'd0;
    localparam logic [STATE_W-1:0] ST_PROCESS = 2'd1;
    localparam logic [STATE_W-1:0] ST_OUTPUT  = 2'd2;

    // Processing steps in issue order
    localparam int STEP_W = 2;
    localparam logic [STEP_W-1:0] STEP_PP   = 2'd0;
    localparam logic [STEP_W-1:0] STEP_RED1 = 2'd1;
    localparam logic [STEP_W-1:0] STEP_RED2 = 2'd2;
    localparam logic [STEP_W-1:0] STEP_ADD  = 2'd3;

    // Returns {carry, sum}
    function automatic logic [1:0] full_add(input logic x, input logic y, input logic z);
        return {(x & y) | (z & (x ^ y)), x ^ y ^ z};
    endfunction

    // Returns {carry, sum}
    function automatic logic [1:0] half_add(input logic x, input logic y);
        return {x & y, x ^ y};
    endfunction

endpackage

/* source/dadda_mul_top.sv */
// 8x8 unsigned Dadda multiplier with valid/ready on both sides
// One operand pair in flight, product 4 cycles after acceptance
`timescale 1ns/1ps

module dadda_mul_top (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic [dadda_mul_pkg::OP_W-1:0]   a,
    input  logic [dadda_mul_pkg::OP_W-1:0]   b,
    input  logic                             valid_in,
    output logic                             ready_in,
    output logic [dadda_mul_pkg::PROD_W-1:0] product,
    output logic                             valid_out,
    input  logic                             ready_out
);
    import dadda_mul_pkg::*;

    logic               accept;
    logic               en_pp;
    logic               en_red1;
    logic               en_red2;
    logic               en_add;
    logic               take;
    logic [PP_BITS-1:0] pp;
    logic [PROD_W-1:0]  sum_row;
    logic [PROD_W-1:0]  carry_row;

    mul_control u_mul_control (
        .clk       (clk),
        .rst_n     (rst_n),
        .valid_in  (valid_in),
        .valid_out (valid_out),
        .ready_out (ready_out),
        .ready_in  (ready_in),
        .accept    (accept),
        .en_pp     (en_pp),
        .en_red1   (en_red1),
        .en_red2   (en_red2),
        .en_add    (en_add),
        .take      (take)
    );

    pp_generator u_pp_generator (
        .clk    (clk),
        .rst_n  (rst_n),
        .accept (accept),
        .en_pp  (en_pp),
        .a      (a),
        .b      (b),
        .pp     (pp)
    );

    dadda_reducer u_dadda_reducer (
        .clk       (clk),
        .rst_n     (rst_n),
        .en_red1   (en_red1),
        .en_red2   (en_red2),
        .pp        (pp),
        .sum_row   (sum_row),
        .carry_row (carry_row)
    );

    final_adder_stage u_final_adder_stage (
        .clk       (clk),
        .rst_n     (rst_n),
        .en_add    (en_add),
        .take      (take),
        .sum_row   (sum_row),
        .carry_row (carry_row),
        .product   (product),
        .valid_out (valid_out)
    );

endmodule

/* source/dadda_reducer.sv */
// Two registered Dadda reduction stages for the 8x8 partial-product array
// Stage 1 takes column heights 8 to 6 to 4, stage 2 takes 4 to 3 to 2
`timescale 1ns/1ps

module dadda_reducer (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              en_red1,
    input  logic                              en_red2,
    input  logic [dadda_mul_pkg::PP_BITS-1:0] pp,
    output logic [dadda_mul_pkg::PROD_W-1:0]  sum_row,
    output logic [dadda_mul_pkg::PROD_W-1:0]  carry_row
);
    import dadda_mul_pkg::*;

    logic [RED1_ROWS-1:0][PROD_W-1:0] red1_d;
    logic [RED1_ROWS-1:0][PROD_W-1:0] red1_q;
    logic [PROD_W-1:0]                sum_d;
    logic [PROD_W-1:0]                carry_d;

    // One Dadda level, adders only where a column would exceed height d
    function automatic void reduce_level(
        input  logic [OP_W-1:0] col_in  [PROD_W],
        input  int              h_in    [PROD_W],
        input  int              d,
        output logic [OP_W-1:0] col_out [PROD_W],
        output int              h_out   [PROD_W]
    );
        int         excess;
        int         src;
        logic       used;
        logic [1:0] cs;
        for (int k = 0; k < PROD_W; k++) begin
            col_out[k] = '0;
            h_out[k]   = 0;
        end
        for (int k = 0; k < PROD_W; k++) begin
            src    = 0;
            excess = h_in[k] + h_out[k] - d;    // h_out[k] holds carries from column k-1
            for (int n = 0; n < OP_W / 2; n++) begin
                used = 1'b0;
                cs   = '0;
                if (excess >= 2 && src + 3 <= h_in[k]) begin
                    cs     = full_add(col_in[k][src], col_in[k][src+1], col_in[k][src+2]);
                    src    = src + 3;
                    excess = excess - 2;
                    used   = 1'b1;
                end else if (excess == 1 && src + 2 <= h_in[k]) begin
                    cs     = half_add(col_in[k][src], col_in[k][src+1]);
                    src    = src + 2;
                    excess = excess - 1;
                    used   = 1'b1;
                end
                if (used) begin
                    col_out[k][h_out[k]] = cs[0];
                    h_out[k] = h_out[k] + 1;
                    // A carry past bit 15 cannot occur in an 8x8 product
                    if (k + 1 < PROD_W) begin
                        col_out[k+1][h_out[k+1]] = cs[1];
                        h_out[k+1] = h_out[k+1] + 1;
                    end
                end
            end
            for (int n = 0; n < OP_W; n++) begin
                if (n >= src && n < h_in[k]) begin  // Untouched bits pass down
                    col_out[k][h_out[k]] = col_in[k][n];
                    h_out[k] = h_out[k] + 1;
                end
            end
        end
    endfunction

    always_comb begin
        logic [OP_W-1:0] col_a [PROD_W];
        logic [OP_W-1:0] col_b [PROD_W];
        int              h_a   [PROD_W];
        int              h_b   [PROD_W];
        for (int k = 0; k < PROD_W; k++) begin
            col_a[k] = '0;
            h_a[k]   = 0;
        end
        for (int i = 0; i < OP_W; i++) begin
            for (int j = 0; j < OP_W; j++) begin
                col_a[i+j][h_a[i+j]] = pp[i*OP_W+j];
                h_a[i+j] = h_a[i+j] + 1;
            end
        end
        reduce_level(col_a, h_a, 6, col_b, h_b);
        reduce_level(col_b, h_b, 4, col_a, h_a);    // h_a now the stage 1 heights
        for (int k = 0; k < PROD_W; k++) begin
            col_b[k] = '0;
            for (int r = 0; r < RED1_ROWS; r++) begin
                red1_d[r][k] = col_a[k][r];
                col_b[k][r]  = red1_q[r][k];        // Stage 2 works on registered rows
            end
        end
        reduce_level(col_b, h_a, 3, col_a, h_b);
        reduce_level(col_a, h_b, 2, col_b, h_a);
        for (int k = 0; k < PROD_W; k++) begin
            sum_d[k]   = col_b[k][0];
            carry_d[k] = col_b[k][1];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            red1_q    <= '0;
            sum_row   <= '0;
            carry_row <= '0;
        end else begin
            if (en_red1) begin
                red1_q <= red1_d;
            end
            if (en_red2) begin
                sum_row   <= sum_d;
                carry_row <= carry_d;
            end
        end
    end

endmodule

/* source/final_adder_stage.sv */
// Carry-propagate add of the two reduced rows
// Holds product and valid_out until the consumer takes them
`timescale 1ns/1ps

module final_adder_stage (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             en_add,
    input  logic                             take,
    input  logic [dadda_mul_pkg::PROD_W-1:0] sum_row,
    input  logic [dadda_mul_pkg::PROD_W-1:0] carry_row,
    output logic [dadda_mul_pkg::PROD_W-1:0] product,
    output logic                             valid_out
);

    // Rows are already aligned, the sum fits in 16 bits
    always_ff @(posedge clk) begin
        if (en_add) begin
            product <= sum_row + carry_row;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_out <= 1'b0;
        end else if (en_add) begin
            valid_out <= 1'b1;
        end else if (take) begin
            valid_out <= 1'b0;      // Held high under back-pressure
        end
    end

endmodule

/* source/mul_control.sv */
// Sequencer for the multiplier pipeline
// Forms both handshakes and issues one strobe per processing step
`timescale 1ns/1ps

module mul_control (
    input  logic clk,
    input  logic rst_n,
    input  logic valid_in,
    input  logic valid_out,
    input  logic ready_out,
    output logic ready_in,
    output logic accept,
    output logic en_pp,
    output logic en_red1,
    output logic en_red2,
    output logic en_add,
    output logic take
);
    import dadda_mul_pkg::*;

    logic [STATE_W-1:0] state;
    logic [STEP_W-1:0]  step;
    logic               in_process;

    assign take     = valid_out && ready_out;
    // Product leaving frees the datapath on the same edge
    assign ready_in = (state == ST_IDLE) || ((state == ST_OUTPUT) && take);
    assign accept   = valid_in && ready_in;

    assign in_process = (state == ST_PROCESS);
    assign en_pp      = in_process && (step == STEP_PP);
    assign en_red1    = in_process && (step == STEP_RED1);
    assign en_red2    = in_process && (step == STEP_RED2);
    assign en_add     = in_process && (step == STEP_ADD);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
            step  <= STEP_PP;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (accept) begin
                        state <= ST_PROCESS;
                        step  <= STEP_PP;
                    end
                end
                ST_PROCESS: begin
                    step <= step + 1'b1;        // Wraps back to STEP_PP after add
                    if (step == STEP_ADD) begin
                        state <= ST_OUTPUT;
                    end
                end
                ST_OUTPUT: begin
                    if (accept) begin
                        state <= ST_PROCESS;    // Back-to-back pair
                        step  <= STEP_PP;
                    end else if (take) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                    step  <= STEP_PP;
                end
            endcase
        end
    end

endmodule

/* source/pp_generator.sv */
// Operand capture and partial-product array
// Bit i*8+j of pp is a[j] AND b[i]
`timescale 1ns/1ps

module pp_generator (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              accept,
    input  logic                              en_pp,
    input  logic [dadda_mul_pkg::OP_W-1:0]    a,
    input  logic [dadda_mul_pkg::OP_W-1:0]    b,
    output logic [dadda_mul_pkg::PP_BITS-1:0] pp
);
    import dadda_mul_pkg::*;

    logic [OP_W-1:0] a_q;
    logic [OP_W-1:0] b_q;

    always_ff @(posedge clk) begin
        if (accept) begin
            a_q <= a;
            b_q <= b;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pp <= '0;
        end else if (en_pp) begin
            for (int i = 0; i < OP_W; i++) begin
                for (int j = 0; j < OP_W; j++) begin
                    pp[i*OP_W+j] <= a_q[j] & b_q[i];    // Weight 2^(i+j)
                end
            end
        end
    end

endmodule

/* verification/dadda_mul_properties.sv */
// Handshake assertions for the Dadda multiplier, bound into the top level
`timescale 1ns/1ps

module dadda_mul_properties (
    input logic                             clk,
    input logic                             rst_n,
    input logic                             valid_in,
    input logic                             ready_in,
    input logic [dadda_mul_pkg::PROD_W-1:0] product,
    input logic                             valid_out,
    input logic                             ready_out
);
    int   error_count = 0;
    logic accept;

    assign accept = valid_in && ready_in;

    hold_while_stalled: assert property (@(posedge clk) disable iff (!rst_n)
        (valid_out && !ready_out) |=> (valid_out && $stable(product)))
        else begin
            error_count++;
            $error("product or valid_out changed under back-pressure");
        end

    // No new operands while the product waits
    busy_while_stalled: assert property (@(posedge clk) disable iff (!rst_n)
        (valid_out && !ready_out) |-> !ready_in)
        else begin
            error_count++;
            $error("ready_in high while the product is stalled");
        end

    no_early_valid: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(valid_out) |-> !($past(accept, 1) || $past(accept, 2) ||
                               $past(accept, 3) || $past(accept, 4)))
        else begin
            error_count++;
            $error("valid_out rose too soon after an accept");
        end

endmodule

bind dadda_mul_top dadda_mul_properties u_dadda_mul_properties (
    .clk       (clk),
    .rst_n     (rst_n),
    .valid_in  (valid_in),
    .ready_in  (ready_in),
    .product   (product),
    .valid_out (valid_out),
    .ready_out (ready_out)
);

/* verification/tb_dadda_mul.sv */
// Testbench for the 8x8 Dadda multiplier
// Directed and random rows, back-pressure, then back-to-back streaming
`timescale 1ns/1ps

module tb_dadda_mul;
    import dadda_mul_pkg::*;

    localparam int N_DIR  = 5;
    localparam int N_ROWS = N_DIR + 40;
    localparam logic [OP_W-1:0] DIR_A [N_DIR] = '{8'd0, 8'd255, 8'd1, 8'd128, 8'd15};
    localparam logic [OP_W-1:0] DIR_B [N_DIR] = '{8'd0, 8'd255, 8'd200, 8'd2, 8'd17};
    localparam int              DIR_STALL [N_DIR] = '{0, 2, 0, 1, 4};

    logic              clk = 1'b0;
    logic              rst_n;
    logic [OP_W-1:0]   a;
    logic [OP_W-1:0]   b;
    logic              valid_in;
    logic              ready_in;
    logic [PROD_W-1:0] product;
    logic              valid_out;
    logic              ready_out;

    // Stimulus table: operands, expected product, ready_out stall cycles
    logic [OP_W-1:0]   row_a     [N_ROWS];
    logic [OP_W-1:0]   row_b     [N_ROWS];
    logic [PROD_W-1:0] row_prod  [N_ROWS];
    int                row_stall [N_ROWS];
    logic [PROD_W-1:0] pending   [$];     // Products owed by the DUT
    int                seed;

    dadda_mul_top u_dadda_mul_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .a         (a),
        .b         (b),
        .valid_in  (valid_in),
        .ready_in  (ready_in),
        .product   (product),
        .valid_out (valid_out),
        .ready_out (ready_out)
    );

    always #2 clk = ~clk;

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1, "Simulation stopped on first error");
    endtask

    task automatic check_product(input logic [PROD_W-1:0] got, input logic [PROD_W-1:0] exp,
                                 input string what);
        if (got !== exp) begin
            stop_run($sformatf("Mismatch at %0t: %s is %0d, expected %0d",
                               $time, what, got, exp));
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            stop_run($sformatf("Mismatch at %0t: %s is %b, expected %b",
                               $time, what, got, exp));
        end
    endtask

    task automatic fill_table();
        for (int i = 0; i < N_ROWS; i++) begin
            if (i < N_DIR) begin
                row_a[i]     = DIR_A[i];
                row_b[i]     = DIR_B[i];
                row_stall[i] = DIR_STALL[i];
            end else begin
                row_a[i]     = OP_W'($random(seed));
                row_b[i]     = OP_W'($random(seed));
                row_stall[i] = $unsigned($random(seed)) % 5;
            end
            row_prod[i] = PROD_W'(int'(row_a[i]) * int'(row_b[i]));
        end
    endtask

    // One pair at a time, product held for the row's stall count
    task automatic run_row(input int i);
        int waited;
        waited = 0;
        @(posedge clk);
        a         <= row_a[i];
        b         <= row_b[i];
        valid_in  <= 1'b1;
        ready_out <= (row_stall[i] == 0);
        do begin
            @(negedge clk);
            waited++;
            if (waited > 8) begin
                stop_run("Timeout: operand pair was never accepted");
            end
        end while (!ready_in);
        @(posedge clk);                     // Accepting edge
        valid_in <= 1'b0;
        for (int k = 0; k <= 4; k++) begin
            @(negedge clk);
            check_flag(valid_out, k == 4, "valid_out after accept");
        end
        for (int s = 0; s < row_stall[i]; s++) begin
            check_flag(ready_in, 1'b0, "ready_in while stalled");
            check_flag(valid_out, 1'b1, "valid_out while stalled");
            check_product(product, row_prod[i], "product while stalled");
            @(posedge clk);
            if (s == row_stall[i] - 1) begin
                ready_out <= 1'b1;
            end
            @(negedge clk);
        end
        check_flag(ready_in, 1'b1, "ready_in during transfer");
        check_product(product, row_prod[i], "product");
        @(posedge clk);                     // Product taken here
        ready_out <= 1'b0;
        @(negedge clk);
        check_flag(valid_out, 1'b0, "valid_out after transfer");
    endtask

    // valid_in and ready_out held high for the whole table
    task automatic run_stream();
        int   accepts;
        int   taken;
        int   cycles;
        logic fire_in;
        logic fire_out;
        logic overlap;
        accepts = 0;
        taken   = 0;
        cycles  = 0;
        overlap = 1'b0;
        @(posedge clk);
        a         <= row_a[0];
        b         <= row_b[0];
        valid_in  <= 1'b1;
        ready_out <= 1'b1;
        while (taken < N_ROWS) begin
            @(negedge clk);
            fire_in  = valid_in && ready_in;
            fire_out = valid_out && ready_out;
            if (fire_in && pending.size() != 0 && !fire_out) begin
                stop_run("Operands accepted while a product was still in flight");
            end
            if (fire_out) begin
                if (pending.size() == 0) begin
                    stop_run("Product delivered without an accepted operand pair");
                end
                check_product(product, pending.pop_front(), "streamed product");
                taken++;
            end
            if (fire_in) begin
                overlap = overlap | fire_out;
                pending.push_back(row_prod[accepts]);
                accepts++;
            end
            cycles++;
            if (cycles > N_ROWS * 8) begin
                stop_run("Timeout: streamed products did not all arrive");
            end
            @(posedge clk);
            if (fire_in && accepts < N_ROWS) begin
                a <= row_a[accepts];
                b <= row_b[accepts];
            end else if (fire_in) begin
                valid_in <= 1'b0;
            end
        end
        check_flag(overlap, 1'b1, "accept on the same edge as a take");
        // No product may follow the last accepted pair
        for (int k = 0; k < 8; k++) begin
            @(negedge clk);
            check_flag(valid_out, 1'b0, "valid_out after the last product");
        end
    endtask

    initial begin
        seed = 95401;
        rst_n     <= 1'b0;
        a         <= '0;
        b         <= '0;
        valid_in  <= 1'b0;
        ready_out <= 1'b0;
        fill_table();
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_flag(ready_in, 1'b1, "ready_in after reset");
        check_flag(valid_out, 1'b0, "valid_out after reset");
        for (int i = 0; i < N_ROWS; i++) begin
            run_row(i);
        end
        run_stream();
        if (u_dadda_mul_top.u_dadda_mul_properties.error_count != 0) begin
            $display("Handshake assertions failed during the run");
            $display("=== FAIL ===");
            $fatal(1, "Assertion failures");
        end else begin
            $display("=== PASS ===");
            $finish;
        end
    end

endmodule
